// File: include/glyph_table.svh
`ifndef GLYPH_TABLE_SVH
`define GLYPH_TABLE_SVH

// ====================
// 5x7 font
// ====================
// Seven rows packed top row first, bit 4 of a row is the leftmost column
function automatic logic [4:0] glyph_bits(
    input flappy_pkg::glyph_code_t code,
    input logic [2:0]              row
);
    logic [34:0] rows;
    logic [5:0]  base;
    rows = '0;
    base = 6'd34 - 6'(row * 5);
    case (code)
        5'd0: rows = {5'b01110, 5'b10001, 5'b10011, 5'b10101,
                      5'b11001, 5'b10001, 5'b01110};
        5'd1: rows = {5'b00100, 5'b01100, 5'b00100, 5'b00100,
                      5'b00100, 5'b00100, 5'b01110};
        5'd2: rows = {5'b01110, 5'b10001, 5'b00001, 5'b00010,
                      5'b00100, 5'b01000, 5'b11111};
        5'd3: rows = {5'b01110, 5'b10001, 5'b00001, 5'b00110,
                      5'b00001, 5'b10001, 5'b01110};
        5'd4: rows = {5'b00010, 5'b00110, 5'b01010, 5'b10010,
                      5'b11111, 5'b00010, 5'b00010};
        5'd5: rows = {5'b11111, 5'b10000, 5'b11110, 5'b00001,
                      5'b00001, 5'b10001, 5'b01110};
        5'd6: rows = {5'b01110, 5'b10000, 5'b11110, 5'b10001,
                      5'b10001, 5'b10001, 5'b01110};
        5'd7: rows = {5'b11111, 5'b00001, 5'b00010, 5'b00100,
                      5'b01000, 5'b01000, 5'b01000};
        5'd8: rows = {5'b01110, 5'b10001, 5'b10001, 5'b01110,
                      5'b10001, 5'b10001, 5'b01110};
        5'd9: rows = {5'b01110, 5'b10001, 5'b10001, 5'b01111,
                      5'b00001, 5'b00001, 5'b01110};

        // Letters of the game-over title
        flappy_pkg::CHAR_G: rows = {5'b01110, 5'b10001, 5'b10000, 5'b10111,
                                    5'b10001, 5'b10001, 5'b01110};
        flappy_pkg::CHAR_A: rows = {5'b01110, 5'b10001, 5'b10001, 5'b11111,
                                    5'b10001, 5'b10001, 5'b10001};
        flappy_pkg::CHAR_M: rows = {5'b10001, 5'b11011, 5'b10101, 5'b10101,
                                    5'b10001, 5'b10001, 5'b10001};
        flappy_pkg::CHAR_E: rows = {5'b11111, 5'b10000, 5'b10000, 5'b11110,
                                    5'b10000, 5'b10000, 5'b11111};
        flappy_pkg::CHAR_O: rows = {5'b01110, 5'b10001, 5'b10001, 5'b10001,
                                    5'b10001, 5'b10001, 5'b01110};
        flappy_pkg::CHAR_V: rows = {5'b10001, 5'b10001, 5'b10001, 5'b10001,
                                    5'b01010, 5'b01010, 5'b00100};
        flappy_pkg::CHAR_R: rows = {5'b11110, 5'b10001, 5'b10001, 5'b11110,
                                    5'b10100, 5'b10010, 5'b10001};
        default: rows = '0; // Space and unused codes stay dark
    endcase

    // Row 7 is the spacing row below the glyph
    if (row == 3'd7) begin
        return 5'b00000;
    end
    return rows[base -: 5];
endfunction

`endif

// File: design/flappy_pkg.sv
`default_nettype none

package flappy_pkg;

    // ====================
    // Colours
    // ====================
    typedef logic [11:0] color_t; // 4 bits each of R, G, B

    localparam color_t BLACK        = 12'h000;
    localparam color_t SKY_COLOR    = 12'h5CC; // Teal sky
    localparam color_t PIPE_COLOR   = 12'h0F0;
    localparam color_t TEXT_COLOR   = 12'hFFF;
    localparam color_t GROUND_COLOR = 12'hDD9; // Sandy tan
    localparam color_t BIRD_COLOR   = 12'hFD0;

    // ====================
    // Screen geometry
    // ====================
    typedef logic [9:0] coord_t;

    localparam integer ACTIVE_X_START = 144;  // First visible column of the scan
    localparam integer ACTIVE_Y_START = 35;
    localparam integer ACTIVE_WIDTH   = 640;
    localparam integer ACTIVE_HEIGHT  = 481;  // Visible lines 35 to 515

    // 5x7 glyph plus one blank column and row, scaled up
    localparam integer PIXEL_SCALE = 2;
    localparam integer CHAR_W      = 6 * PIXEL_SCALE;
    localparam integer CHAR_H      = 8 * PIXEL_SCALE;

    localparam integer BIRD_X   = 200;
    localparam integer BIRD_W   = 24;
    localparam integer BIRD_H   = 24;
    localparam integer GROUND_H = 24;

    // ====================
    // Text layout
    // ====================
    localparam integer GO_LEN     = 9; // "GAME OVER"
    localparam integer SCORE_Y    = ACTIVE_Y_START + CHAR_H;
    localparam integer GO_Y       = ACTIVE_Y_START + (ACTIVE_HEIGHT / 2) - CHAR_H;
    localparam integer GO_SCORE_Y = GO_Y + CHAR_H + (4 * PIXEL_SCALE);

    // Glyph codes, 0 to 9 are the digits themselves
    typedef logic [4:0] glyph_code_t;

    localparam glyph_code_t CHAR_G     = 5'd10;
    localparam glyph_code_t CHAR_A     = 5'd11;
    localparam glyph_code_t CHAR_M     = 5'd12;
    localparam glyph_code_t CHAR_E     = 5'd13;
    localparam glyph_code_t CHAR_O     = 5'd14;
    localparam glyph_code_t CHAR_V     = 5'd15;
    localparam glyph_code_t CHAR_R     = 5'd16;
    localparam glyph_code_t CHAR_SPACE = 5'd31;

    typedef enum logic {
        PLAYING = 1'b0,
        OVER    = 1'b1
    } game_state_t;

endpackage

`default_nettype wire

// File: design/score_keeper.sv
`timescale 1ns/100ps
`default_nettype none

module score_keeper #(
    parameter int SCORE_W = 16
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    bird_alive,
    input  wire logic                    pipe_passed,
    output logic [SCORE_W-1:0]           score,
    output logic [3:0][3:0]              digits,     // digits[0] is the units digit
    output flappy_pkg::game_state_t      game_state
);

    logic           point;       // Qualified pipe strobe
    logic           prev_alive;
    logic [3:0][3:0] next_digits;
    logic           carry;

    assign point = pipe_passed && bird_alive;

    // ====================
    // Decimal digit counter
    // ====================
    // Ripple a carry through the BCD digits, 9999 rolls back to 0
    always_comb begin
        carry = 1'b1;
        for (int i = 0; i < 4; i++) begin
            next_digits[i] = digits[i];
            if (carry) begin
                if (digits[i] == 4'd9) begin
                    next_digits[i] = 4'd0;
                end else begin
                    next_digits[i] = digits[i] + 4'd1;
                    carry          = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score  <= '0;
            digits <= '0;
        end else if (point) begin
            score  <= score + 1'b1;
            digits <= next_digits;
        end
    end

    // ====================
    // Game state
    // ====================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prev_alive <= 1'b0;
            game_state <= flappy_pkg::PLAYING;
        end else begin
            prev_alive <= bird_alive;
            if (bird_alive) begin
                game_state <= flappy_pkg::PLAYING;
            end else if (prev_alive) begin
                game_state <= flappy_pkg::OVER; // Falling edge of alive
            end
        end
    end

endmodule

`default_nettype wire

// File: design/text_overlay.sv
`timescale 1ns/100ps
`default_nettype none

module text_overlay (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire flappy_pkg::coord_t      h_count,
    input  wire flappy_pkg::coord_t      v_count,
    input  wire logic [3:0][3:0]         digits,
    input  wire flappy_pkg::game_state_t game_state,
    output logic                         text_on
);

    `include "glyph_table.svh"

    // Title is fixed, so its left edge is a constant
    localparam flappy_pkg::coord_t GO_X0 = flappy_pkg::coord_t'(flappy_pkg::ACTIVE_X_START +
        (flappy_pkg::ACTIVE_WIDTH - flappy_pkg::GO_LEN * flappy_pkg::CHAR_W) / 2);

    logic                    over;
    logic [2:0]              score_len;   // 1 to 4 shown digits
    flappy_pkg::coord_t      score_w_px;
    flappy_pkg::coord_t      score_x0;
    flappy_pkg::coord_t      score_dx;
    flappy_pkg::coord_t      score_dy;
    flappy_pkg::coord_t      go_dx;
    flappy_pkg::coord_t      go_dy;
    logic                    score_in_x;
    logic                    score_row_top;
    logic                    score_row_go;
    logic                    go_in_x;
    logic                    go_row;
    logic [1:0]              score_idx;
    logic [1:0]              score_sel;
    logic [3:0]              go_idx;
    flappy_pkg::glyph_code_t score_code;
    logic                    text_next;

    // Lit test for a pixel at offset dx, dy from the top left of a text line
    function automatic logic glyph_pixel(
        input flappy_pkg::glyph_code_t code,
        input flappy_pkg::coord_t      dx,
        input flappy_pkg::coord_t      dy
    );
        logic [2:0] col;
        logic [3:0] row;
        logic [4:0] bits;
        col  = 3'((dx % flappy_pkg::CHAR_W) / flappy_pkg::PIXEL_SCALE);
        row  = 4'(dy / flappy_pkg::PIXEL_SCALE);
        bits = glyph_bits(code, row[2:0]);
        if ((col < 3'd5) && (row < 4'd7)) begin
            return bits[3'd4 - col];
        end
        return 1'b0;
    endfunction

    function automatic flappy_pkg::glyph_code_t go_code(input logic [3:0] idx);
        case (idx)
            4'd0:    return flappy_pkg::CHAR_G;
            4'd1:    return flappy_pkg::CHAR_A;
            4'd2:    return flappy_pkg::CHAR_M;
            4'd3:    return flappy_pkg::CHAR_E;
            4'd5:    return flappy_pkg::CHAR_O;
            4'd6:    return flappy_pkg::CHAR_V;
            4'd7:    return flappy_pkg::CHAR_E;
            4'd8:    return flappy_pkg::CHAR_R;
            default: return flappy_pkg::CHAR_SPACE;
        endcase
    endfunction

    assign over = (game_state == flappy_pkg::OVER);

    // ====================
    // Score line
    // ====================
    // Leading zeros suppressed, a lone zero still shows
    always_comb begin
        if (digits[3] != 4'd0) begin
            score_len = 3'd4;
        end else if (digits[2] != 4'd0) begin
            score_len = 3'd3;
        end else if (digits[1] != 4'd0) begin
            score_len = 3'd2;
        end else begin
            score_len = 3'd1;
        end
    end

    assign score_w_px = flappy_pkg::coord_t'(score_len * flappy_pkg::CHAR_W);
    assign score_x0   = flappy_pkg::coord_t'(flappy_pkg::ACTIVE_X_START +
                        (flappy_pkg::ACTIVE_WIDTH - score_w_px) / 2);
    assign score_dx   = h_count - score_x0;
    assign score_in_x = (h_count >= score_x0) && (h_count < score_x0 + score_w_px);

    assign score_row_top = (v_count >= flappy_pkg::SCORE_Y) &&
                           (v_count < flappy_pkg::SCORE_Y + flappy_pkg::CHAR_H);
    assign score_row_go  = over && (v_count >= flappy_pkg::GO_SCORE_Y) &&
                           (v_count < flappy_pkg::GO_SCORE_Y + flappy_pkg::CHAR_H);
    assign score_dy      = score_row_top ?
                           flappy_pkg::coord_t'(v_count - flappy_pkg::SCORE_Y) :
                           flappy_pkg::coord_t'(v_count - flappy_pkg::GO_SCORE_Y);

    // Leftmost shown character is the most significant digit
    assign score_idx  = 2'(score_dx / flappy_pkg::CHAR_W);
    assign score_sel  = 2'(score_len - 3'd1 - {1'b0, score_idx});
    assign score_code = {1'b0, digits[score_sel]};

    // ====================
    // Title line
    // ====================
    assign go_dx   = h_count - GO_X0;
    assign go_dy   = flappy_pkg::coord_t'(v_count - flappy_pkg::GO_Y);
    assign go_idx  = 4'(go_dx / flappy_pkg::CHAR_W);
    assign go_in_x = (h_count >= GO_X0) &&
                     (h_count < GO_X0 + flappy_pkg::GO_LEN * flappy_pkg::CHAR_W);
    assign go_row  = over && (v_count >= flappy_pkg::GO_Y) &&
                     (v_count < flappy_pkg::GO_Y + flappy_pkg::CHAR_H);

    assign text_next = ((score_row_top || score_row_go) && score_in_x &&
                        glyph_pixel(score_code, score_dx, score_dy)) ||
                       (go_row && go_in_x && glyph_pixel(go_code(go_idx), go_dx, go_dy));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            text_on <= 1'b0;
        end else begin
            text_on <= text_next;
        end
    end

endmodule

`default_nettype wire

// File: design/scene_layer.sv
`timescale 1ns/100ps
`default_nettype none

module scene_layer (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire flappy_pkg::coord_t h_count,
    input  wire flappy_pkg::coord_t v_count,
    input  wire flappy_pkg::coord_t bird_y,   // Top row of the bird box
    input  wire logic               pipe_pixel,
    output flappy_pkg::color_t      scene_rgb
);

    // Ground band sits on the last visible lines
    localparam integer GROUND_Y = flappy_pkg::ACTIVE_Y_START + flappy_pkg::ACTIVE_HEIGHT -
                                  flappy_pkg::GROUND_H;
    localparam integer GROUND_END = flappy_pkg::ACTIVE_Y_START + flappy_pkg::ACTIVE_HEIGHT;

    logic               bird_on;
    logic               ground_on;
    flappy_pkg::color_t scene_next;

    // Compared at integer width so bird_y near the bottom cannot wrap
    assign bird_on = (h_count >= flappy_pkg::BIRD_X) &&
                     (h_count < flappy_pkg::BIRD_X + flappy_pkg::BIRD_W) &&
                     (v_count >= bird_y) &&
                     (v_count < bird_y + flappy_pkg::BIRD_H);

    assign ground_on = (v_count >= GROUND_Y) && (v_count < GROUND_END);

    // ====================
    // Layer priority
    // ====================
    always_comb begin
        if (bird_on) begin
            scene_next = flappy_pkg::BIRD_COLOR;
        end else if (ground_on) begin
            scene_next = flappy_pkg::GROUND_COLOR; // Ground hides pipe feet
        end else if (pipe_pixel) begin
            scene_next = flappy_pkg::PIPE_COLOR;
        end else begin
            scene_next = flappy_pkg::SKY_COLOR;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scene_rgb <= flappy_pkg::BLACK;
        end else begin
            scene_rgb <= scene_next;
        end
    end

endmodule

`default_nettype wire

// File: design/pixel_mixer.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_mixer (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               bright,     // High in the visible window
    input  wire logic               text_on,
    input  wire flappy_pkg::color_t scene_rgb,
    output flappy_pkg::color_t      rgb
);

    logic bright_d; // Lines up with the registered layer outputs

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bright_d <= 1'b0;
        end else begin
            bright_d <= bright;
        end
    end

    // ====================
    // Output stage
    // ====================
    // Text sits above every scene layer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rgb <= flappy_pkg::BLACK;
        end else if (!bright_d) begin
            rgb <= flappy_pkg::BLACK;
        end else if (text_on) begin
            rgb <= flappy_pkg::TEXT_COLOR;
        end else begin
            rgb <= scene_rgb;
        end
    end

endmodule

`default_nettype wire

// File: design/flappy_display.sv
`timescale 1ns/100ps
`default_nettype none

module flappy_display #(
    parameter int SCORE_W = 16
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               bright,
    input  wire flappy_pkg::coord_t h_count,
    input  wire flappy_pkg::coord_t v_count,
    input  wire flappy_pkg::coord_t bird_y,
    input  wire logic               bird_alive,
    input  wire logic               pipe_passed,
    input  wire logic               pipe_pixel,
    output flappy_pkg::color_t      rgb,
    output logic [SCORE_W-1:0]      score,
    output logic                    game_over
);

    logic [3:0][3:0]         digits;
    flappy_pkg::game_state_t game_state;
    logic                    text_on;
    flappy_pkg::color_t      scene_rgb;

    assign game_over = (game_state == flappy_pkg::OVER);

    score_keeper #(
        .SCORE_W(SCORE_W)
    ) score_keeper_i (
        .clk        (clk),
        .reset      (reset),
        .bird_alive (bird_alive),
        .pipe_passed(pipe_passed),
        .score      (score),
        .digits     (digits),
        .game_state (game_state)
    );

    // Text and scene run side by side, one stage each
    text_overlay text_overlay_i (
        .clk       (clk),
        .reset     (reset),
        .h_count   (h_count),
        .v_count   (v_count),
        .digits    (digits),
        .game_state(game_state),
        .text_on   (text_on)
    );

    scene_layer scene_layer_i (
        .clk       (clk),
        .reset     (reset),
        .h_count   (h_count),
        .v_count   (v_count),
        .bird_y    (bird_y),
        .pipe_pixel(pipe_pixel),
        .scene_rgb (scene_rgb)
    );

    pixel_mixer pixel_mixer_i (
        .clk      (clk),
        .reset    (reset),
        .bright   (bright),
        .text_on  (text_on),
        .scene_rgb(scene_rgb),
        .rgb      (rgb)
    );

endmodule

`default_nettype wire

// File: test/flappy_model_pkg.sv
`default_nettype none

package flappy_model_pkg;

    int                      score_count;
    bit                      prev_alive;
    flappy_pkg::game_state_t state;

    // ====================
    // Score and game state
    // ====================
    function automatic void clear_state();
        score_count = 0;
        prev_alive  = 1'b0;
        state       = flappy_pkg::PLAYING;
    endfunction

    // One clock edge of the keeper rules
    function automatic void step_game(input bit alive, input bit passed);
        if (alive && passed) begin
            score_count++;
        end
        if (alive) begin
            state = flappy_pkg::PLAYING;
        end else if (prev_alive) begin
            state = flappy_pkg::OVER; // Bird just died
        end
        prev_alive = alive;
    endfunction

    // ====================
    // Font
    // ====================
    // Top row in the high bits, leftmost column is the high bit of a row
    function automatic logic [34:0] font_rows(input int code);
        case (code)
            0:  return {5'b01110, 5'b10001, 5'b10011, 5'b10101, 5'b11001, 5'b10001, 5'b01110};
            1:  return {5'b00100, 5'b01100, 5'b00100, 5'b00100, 5'b00100, 5'b00100, 5'b01110};
            2:  return {5'b01110, 5'b10001, 5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b11111};
            3:  return {5'b01110, 5'b10001, 5'b00001, 5'b00110, 5'b00001, 5'b10001, 5'b01110};
            4:  return {5'b00010, 5'b00110, 5'b01010, 5'b10010, 5'b11111, 5'b00010, 5'b00010};
            5:  return {5'b11111, 5'b10000, 5'b11110, 5'b00001, 5'b00001, 5'b10001, 5'b01110};
            6:  return {5'b01110, 5'b10000, 5'b11110, 5'b10001, 5'b10001, 5'b10001, 5'b01110};
            7:  return {5'b11111, 5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b01000, 5'b01000};
            8:  return {5'b01110, 5'b10001, 5'b10001, 5'b01110, 5'b10001, 5'b10001, 5'b01110};
            9:  return {5'b01110, 5'b10001, 5'b10001, 5'b01111, 5'b00001, 5'b00001, 5'b01110};
            10: return {5'b01110, 5'b10001, 5'b10000, 5'b10111, 5'b10001, 5'b10001, 5'b01110};
            11: return {5'b01110, 5'b10001, 5'b10001, 5'b11111, 5'b10001, 5'b10001, 5'b10001};
            12: return {5'b10001, 5'b11011, 5'b10101, 5'b10101, 5'b10001, 5'b10001, 5'b10001};
            13: return {5'b11111, 5'b10000, 5'b10000, 5'b11110, 5'b10000, 5'b10000, 5'b11111};
            14: return {5'b01110, 5'b10001, 5'b10001, 5'b10001, 5'b10001, 5'b10001, 5'b01110};
            15: return {5'b10001, 5'b10001, 5'b10001, 5'b10001, 5'b01010, 5'b01010, 5'b00100};
            16: return {5'b11110, 5'b10001, 5'b10001, 5'b11110, 5'b10100, 5'b10010, 5'b10001};
            default: return '0; // Space
        endcase
    endfunction

    // dx counts from the left edge of the text line, dy from the top of the cell
    function automatic bit glyph_lit(input int code, input int dx, input int dy);
        int          col;
        int          row;
        logic [34:0] rows;
        col  = (dx % flappy_pkg::CHAR_W) / flappy_pkg::PIXEL_SCALE;
        row  = dy / flappy_pkg::PIXEL_SCALE;
        rows = font_rows(code);
        if (col > 4 || row > 6) begin
            return 1'b0; // Spacing column or row
        end
        return rows[34 - row * 5 - col];
    endfunction

    // ====================
    // Text and pixel colour
    // ====================
    function automatic bit text_lit(input int h, input int v);
        int title[9];
        int value;
        int len;
        int x0;
        int dx;
        int place;
        int digit;
        bit lit;
        title = '{10, 11, 12, 13, 31, 14, 15, 13, 16}; // G A M E space O V E R
        value = score_count % 10000;
        len   = (value >= 1000) ? 4 : (value >= 100) ? 3 : (value >= 10) ? 2 : 1;
        x0    = flappy_pkg::ACTIVE_X_START + (flappy_pkg::ACTIVE_WIDTH - len * flappy_pkg::CHAR_W) / 2;
        lit   = 1'b0;
        if (h >= x0 && h < x0 + len * flappy_pkg::CHAR_W) begin
            dx    = h - x0;
            place = 1;
            for (int i = dx / flappy_pkg::CHAR_W; i < len - 1; i++) begin
                place = place * 10;
            end
            digit = (value / place) % 10;
            if (v >= flappy_pkg::SCORE_Y && v < flappy_pkg::SCORE_Y + flappy_pkg::CHAR_H) begin
                lit = glyph_lit(digit, dx, v - flappy_pkg::SCORE_Y);
            end
            if (state == flappy_pkg::OVER && v >= flappy_pkg::GO_SCORE_Y &&
                v < flappy_pkg::GO_SCORE_Y + flappy_pkg::CHAR_H) begin
                lit = glyph_lit(digit, dx, v - flappy_pkg::GO_SCORE_Y);
            end
        end
        x0 = flappy_pkg::ACTIVE_X_START +
             (flappy_pkg::ACTIVE_WIDTH - flappy_pkg::GO_LEN * flappy_pkg::CHAR_W) / 2;
        if (state == flappy_pkg::OVER && h >= x0 &&
            h < x0 + flappy_pkg::GO_LEN * flappy_pkg::CHAR_W &&
            v >= flappy_pkg::GO_Y && v < flappy_pkg::GO_Y + flappy_pkg::CHAR_H) begin
            dx  = h - x0;
            lit = lit || glyph_lit(title[dx / flappy_pkg::CHAR_W], dx, v - flappy_pkg::GO_Y);
        end
        return lit;
    endfunction

    function automatic flappy_pkg::color_t expected_pixel(
        input bit bright,
        input int h,
        input int v,
        input int bird_y,
        input bit pipe
    );
        int ground_top;
        ground_top = flappy_pkg::ACTIVE_Y_START + flappy_pkg::ACTIVE_HEIGHT - flappy_pkg::GROUND_H;
        if (!bright) begin
            return flappy_pkg::BLACK;
        end
        if (text_lit(h, v)) begin
            return flappy_pkg::TEXT_COLOR;
        end
        if (h >= flappy_pkg::BIRD_X && h < flappy_pkg::BIRD_X + flappy_pkg::BIRD_W &&
            v >= bird_y && v < bird_y + flappy_pkg::BIRD_H) begin
            return flappy_pkg::BIRD_COLOR;
        end
        if (v >= ground_top && v < ground_top + flappy_pkg::GROUND_H) begin
            return flappy_pkg::GROUND_COLOR;
        end
        return pipe ? flappy_pkg::PIPE_COLOR : flappy_pkg::SKY_COLOR;
    endfunction

endpackage

`default_nettype wire

// File: test/tb_flappy_display.sv
`timescale 1ns/100ps
`default_nettype none

module tb_flappy_display;

    localparam int SCORE_W    = 16;
    localparam int WAIT_LIMIT = 20;   // Cycles allowed for the game-over flag
    localparam int STEP_LIMIT = 2000; // Cycles allowed to reach a score

    logic               clk;
    logic               reset;
    logic               bright;
    logic [9:0]         h_count;
    logic [9:0]         v_count;
    logic [9:0]         bird_y;
    logic               bird_alive;
    logic               pipe_passed;
    logic               pipe_pixel;
    flappy_pkg::color_t rgb;
    logic [SCORE_W-1:0] score;
    logic               game_over;

    string              test_name;
    flappy_pkg::color_t expected_q[$]; // Two pixels in flight

    flappy_display #(
        .SCORE_W(SCORE_W)
    ) flappy_display_i (
        .clk        (clk),
        .reset      (reset),
        .bright     (bright),
        .h_count    (h_count),
        .v_count    (v_count),
        .bird_y     (bird_y),
        .bird_alive (bird_alive),
        .pipe_passed(pipe_passed),
        .pipe_pixel (pipe_pixel),
        .rgb        (rgb),
        .score      (score),
        .game_over  (game_over)
    );

    always #5 clk = ~clk;

    // ====================
    // Checks
    // ====================
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    task automatic apply_reset();
        reset       = 1'b1;
        bright      = 1'b0;
        h_count     = '0;
        v_count     = '0;
        bird_y      = '0;
        bird_alive  = 1'b0;
        pipe_passed = 1'b0;
        pipe_pixel  = 1'b0;
        expected_q.delete();
        flappy_model_pkg::clear_state();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value({test_name, " rgb"}, flappy_pkg::BLACK, rgb);
        check_value({test_name, " score"}, 0, score);
        check_value({test_name, " game over"}, 0, game_over);
    endtask

    // Checks the outputs of earlier cycles, then drives one new pixel
    task automatic drive_cycle(input bit b, input int h, input int v, input int by,
                               input bit pipe, input bit alive, input bit passed);
        flappy_pkg::color_t expected;
        @(negedge clk);
        check_value({test_name, " score"}, flappy_model_pkg::score_count % (1 << SCORE_W), score);
        check_value({test_name, " game over"}, flappy_model_pkg::state == flappy_pkg::OVER,
                    game_over);
        if (expected_q.size() == 2) begin
            check_value({test_name, " rgb"}, expected_q.pop_front(), rgb);
        end
        bright      = b;
        h_count     = 10'(h);
        v_count     = 10'(v);
        bird_y      = 10'(by);
        pipe_pixel  = pipe;
        bird_alive  = alive;
        pipe_passed = passed;
        expected = flappy_model_pkg::expected_pixel(b, h, v, by, pipe);
        expected_q.push_back(expected);
        flappy_model_pkg::step_game(alive, passed);
    endtask

    task automatic random_cycle(input bit alive, input bit passed);
        int h;
        int v;
        int by;
        by = $urandom_range(491, 35);
        h  = $urandom_range(799, 0);
        v  = $urandom_range(524, 0);
        if ($urandom_range(3, 0) == 0) begin // Aim at the bird box and its edges
            h = flappy_pkg::BIRD_X - 2 + $urandom_range(27, 0);
            v = by - 2 + $urandom_range(27, 0);
        end
        drive_cycle($urandom_range(3, 0) != 0, h, v, by, 1'($urandom_range(1, 0)), alive, passed);
    endtask

    task automatic wait_game_over(input bit level, input bit alive);
        int cycles;
        cycles = 0;
        while (game_over !== level) begin
            if (cycles == WAIT_LIMIT) begin
                fail_run("game over flag did not change before the timeout");
            end
            random_cycle(alive, 1'b0);
            cycles++;
        end
    endtask

    task automatic reach_score(input int target);
        int steps;
        steps = 0;
        while (flappy_model_pkg::score_count < target) begin
            if (steps == STEP_LIMIT) begin
                fail_run("score did not reach its target before the timeout");
            end
            random_cycle(1'b1, 1'b1);
            steps++;
        end
    endtask

    // Full rows around the centred text, bird kept out of the way
    task automatic sweep_rows(input int v_first, input int v_last, input bit alive);
        int by;
        for (int v = v_first; v <= v_last; v++) begin
            by = $urandom_range(491, 35);
            for (int h = 400; h <= 530; h++) begin
                drive_cycle(1'b1, h, v, by, 1'($urandom_range(1, 0)), alive, 1'b0);
            end
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        void'($urandom(32'h82f3));
        clk       = 1'b0;
        test_name = "reset";
        apply_reset();
        repeat (4) drive_cycle(1'b0, 300, 100, 100, 1'b0, 1'b0, 1'b0);

        test_name = "scoring";
        repeat (400) random_cycle($urandom_range(3, 0) != 0, $urandom_range(2, 0) == 0);

        test_name = "game over";
        repeat (3) random_cycle(1'b1, 1'b0);
        random_cycle(1'b0, 1'b0);
        wait_game_over(1'b1, 1'b0);
        repeat (6) random_cycle(1'b0, 1'b1); // Strobes while dead score nothing
        random_cycle(1'b1, 1'b0);
        wait_game_over(1'b0, 1'b1);

        test_name = "scene";
        repeat (2000) random_cycle(1'b1, 1'b0);

        test_name = "text";
        apply_reset();
        reach_score(7);
        sweep_rows(flappy_pkg::SCORE_Y - 1, flappy_pkg::SCORE_Y + flappy_pkg::CHAR_H, 1'b1);
        reach_score(42);
        sweep_rows(flappy_pkg::SCORE_Y - 1, flappy_pkg::SCORE_Y + flappy_pkg::CHAR_H, 1'b1);
        reach_score(305);
        sweep_rows(flappy_pkg::SCORE_Y - 1, flappy_pkg::SCORE_Y + flappy_pkg::CHAR_H, 1'b1);
        reach_score(1234);
        sweep_rows(flappy_pkg::SCORE_Y - 1, flappy_pkg::SCORE_Y + flappy_pkg::CHAR_H, 1'b1);
        random_cycle(1'b0, 1'b0);
        wait_game_over(1'b1, 1'b0);
        sweep_rows(flappy_pkg::GO_Y - 1, flappy_pkg::GO_SCORE_Y + flappy_pkg::CHAR_H, 1'b0);

        repeat (2) random_cycle(1'b0, 1'b0); // Drain the pixels still in flight
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
design/flappy_pkg.sv
design/score_keeper.sv
design/text_overlay.sv
design/scene_layer.sv
design/pixel_mixer.sv
design/flappy_display.sv
test/flappy_model_pkg.sv
test/tb_flappy_display.sv
